// ==== phase_aligner_defines.svh ====
// --------------------------------------
// Widths, DRP addresses, masks and CDR
// step constants for the bitslip logic.
// Included by the package and the RTL.
// --------------------------------------
`ifndef PHASE_ALIGNER_DEFINES_SVH
`define PHASE_ALIGNER_DEFINES_SVH

// Bus widths
`define PA_DRP_ADDR_W           10
`define PA_DRP_DATA_W           16
`define PA_CDR_PI_W             7

// MGT DRP register addresses
`define PA_ADDR_DMONITOR_CFG1   10'h03A
`define PA_ADDR_RXCDR_CFG1      10'h00F

// DMONITOR_CFG1 bits kept on the write-back
`define PA_MASK_DMONITOR_CFG1   16'h00FF

// Upper byte of DMONITOR_CFG1, selects CDR PI monitoring
`define PA_DMON_SEL_CDR         8'h01

// PI field position inside RXCDR_CFG1
`define PA_CDR_PI_SHIFT         9

// One bitslip walks the PI a full turn in these steps
`define PA_CDR_STEP_SIZE        32
`define PA_CDR_NUM_STEPS        4

`endif

// ==== phase_aligner_pkg.sv ====
// --------------------------------------
// Shared types for the recovered-clock
// bitslip design: DRP words, PI value,
// DRP operation and sequencer states.
// --------------------------------------
`include "phase_aligner_defines.svh"

package phase_aligner_pkg;

    // DRP bus words
    typedef logic [`PA_DRP_ADDR_W-1:0] drp_addr_t;
    typedef logic [`PA_DRP_DATA_W-1:0] drp_data_t;

    // CDR phase interpolator value
    typedef logic [`PA_CDR_PI_W-1:0] cdr_pi_t;

    // DRP access type
    typedef enum logic {
        drp_read,
        drp_write
    } drp_op_t;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        reset_s,
        dmon_read_s,
        dmon_write_s,
        idle_s,
        cdr_step_s
    } seq_state_t;

endpackage

// ==== drp_req_if.sv ====
// --------------------------------------
// One DRP request and its completion,
// from the sequencer to the DRP port.
// req is held until the done pulse.
// --------------------------------------
`timescale 1ns/1ps

interface drp_req_if;
    import phase_aligner_pkg::*;

    // Request side
    logic      req;
    drp_op_t   op;
    drp_addr_t addr;
    drp_data_t wdata;

    // Completion side, rdata valid with done on reads
    logic      done;
    drp_data_t rdata;

    modport requester (
        output req,
        output op,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport port (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

// ==== mgt_drp_port.sv ====
// --------------------------------------
// MGT DRP master. Turns one request from
// drp_req_if into an enable/ready cycle
// on the DRP pins and returns read data.
// --------------------------------------
`timescale 1ns/1ps

module mgt_drp_port (
    input  logic                         i_clk_freerun,
    input  logic                         i_rst_clk_freerun,
    // Request from the sequencer
    drp_req_if.port                      drp,
    // MGT DRP pins
    output logic                         o_mgt_drpen,
    output logic                         o_mgt_drpwe,
    output phase_aligner_pkg::drp_addr_t o_mgt_drpaddr,
    output phase_aligner_pkg::drp_data_t o_mgt_drpdi,
    input  logic                         i_mgt_drprdy,
    input  phase_aligner_pkg::drp_data_t i_mgt_drpdo
);
    import phase_aligner_pkg::*;

    logic      start;
    logic      finish;
    logic      done_q;
    drp_data_t rdata_q;

    // New access only when idle and not in the done cycle of the last one
    assign start  = drp.req & ~o_mgt_drpen & ~done_q;
    assign finish = o_mgt_drpen & i_mgt_drprdy;

    // --------------------------------------
    // Enable and completion
    // --------------------------------------
    always_ff @(posedge i_clk_freerun) begin
        if (i_rst_clk_freerun) begin
            o_mgt_drpen <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            // Enable held until the slave answers
            if (start) begin
                o_mgt_drpen <= 1'b1;
            end else if (finish) begin
                o_mgt_drpen <= 1'b0;
            end
            done_q <= finish;
        end
    end

    // --------------------------------------
    // Pin registers and read capture
    // --------------------------------------
    always_ff @(posedge i_clk_freerun) begin
        // Latched once per access, stable while enable is high
        if (start) begin
            o_mgt_drpwe   <= (drp.op == drp_write);
            o_mgt_drpaddr <= drp.addr;
            o_mgt_drpdi   <= drp.wdata;
        end
        if (finish && !o_mgt_drpwe) begin
            rdata_q <= i_mgt_drpdo;
        end
    end

    // Completion back to the requester
    assign drp.done  = done_q;
    assign drp.rdata = rdata_q;

endmodule

// ==== bitslip_sequencer.sv ====
// --------------------------------------
// Startup DMONITOR setup, then one CDR PI
// walk per rising edge of i_bitslip. All
// DRP traffic goes out on drp_req_if.
// --------------------------------------
`timescale 1ns/1ps
`include "phase_aligner_defines.svh"

module bitslip_sequencer (
    input  logic                         i_clk_freerun,
    input  logic                         i_rst_clk_freerun,
    // User bitslip request
    input  logic                         i_bitslip,
    // MGT DMONITOR output, PI value in the low bits
    input  phase_aligner_pkg::drp_data_t i_dmonitorout,
    // DRP request towards the port
    drp_req_if.requester                 drp,
    // Status and CDR override
    output logic                         o_bitslip_rdy,
    output logic                         o_rxcdrovrden
);
    import phase_aligner_pkg::*;

    localparam int unsigned STEP_CNT_W = $clog2(`PA_CDR_NUM_STEPS);

    seq_state_t state;

    // DMONITOR_CFG1 as read at startup
    drp_data_t dmon_cfg_q;
    drp_data_t dmon_wdata;

    // Bitslip edge detect
    logic bitslip_q;
    logic bitslip_edge;

    // PI walk
    cdr_pi_t                 cdr_pi_q;
    logic [STEP_CNT_W-1:0]   step_cnt;
    logic                    last_step;
    logic                    step_done;

    assign bitslip_edge = i_bitslip & ~bitslip_q;

    assign step_done = (state == cdr_step_s) & drp.done;
    assign last_step = (step_cnt == STEP_CNT_W'(`PA_CDR_NUM_STEPS - 1));

    // Low byte kept, monitor select in the upper byte
    assign dmon_wdata = (dmon_cfg_q & `PA_MASK_DMONITOR_CFG1)
                      | (drp_data_t'(`PA_DMON_SEL_CDR) << 8);

    // --------------------------------------
    // State machine
    // --------------------------------------
    always_ff @(posedge i_clk_freerun) begin
        if (i_rst_clk_freerun) begin
            state <= reset_s;
        end else begin
            case (state)
                reset_s: begin
                    state <= dmon_read_s;
                end
                // Fetch current DMONITOR configuration
                dmon_read_s: begin
                    if (drp.done) begin
                        state <= dmon_write_s;
                    end
                end
                // Switch monitor to CDR PI
                dmon_write_s: begin
                    if (drp.done) begin
                        state <= idle_s;
                    end
                end
                // Edges arriving in any other state are dropped
                idle_s: begin
                    if (bitslip_edge) begin
                        state <= cdr_step_s;
                    end
                end
                cdr_step_s: begin
                    if (drp.done && last_step) begin
                        state <= idle_s;
                    end
                end
                default: begin
                    state <= reset_s;
                end
            endcase
        end
    end

    // Ready one cycle after idle is entered, dropped right after an edge
    always_ff @(posedge i_clk_freerun) begin
        if (i_rst_clk_freerun) begin
            bitslip_q     <= 1'b0;
            o_bitslip_rdy <= 1'b0;
        end else begin
            bitslip_q     <= i_bitslip;
            o_bitslip_rdy <= (state == idle_s) & ~bitslip_edge;
        end
    end

    // Keep the read value for the write-back
    always_ff @(posedge i_clk_freerun) begin
        if (state == dmon_read_s && drp.done) begin
            dmon_cfg_q <= drp.rdata;
        end
    end

    // --------------------------------------
    // CDR PI walk
    // --------------------------------------
    always_ff @(posedge i_clk_freerun) begin
        if (i_rst_clk_freerun) begin
            step_cnt <= '0;
        end else if (state == idle_s) begin
            step_cnt <= '0;
        end else if (step_done) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // PI advanced before each write, wraps at 128
    always_ff @(posedge i_clk_freerun) begin
        if (state == idle_s && bitslip_edge) begin
            cdr_pi_q <= i_dmonitorout[`PA_CDR_PI_W-1:0] + cdr_pi_t'(`PA_CDR_STEP_SIZE);
        end else if (step_done && !last_step) begin
            cdr_pi_q <= cdr_pi_q + cdr_pi_t'(`PA_CDR_STEP_SIZE);
        end
    end

    // Override strobe in each PI write's done cycle
    assign o_rxcdrovrden = step_done;

    // --------------------------------------
    // DRP request decode
    // --------------------------------------
    always_comb begin
        drp.req   = 1'b0;
        drp.op    = drp_write;
        drp.addr  = `PA_ADDR_DMONITOR_CFG1;
        drp.wdata = '0;
        case (state)
            dmon_read_s: begin
                drp.req = 1'b1;
                drp.op  = drp_read;
            end
            dmon_write_s: begin
                drp.req   = 1'b1;
                drp.wdata = dmon_wdata;
            end
            cdr_step_s: begin
                drp.req   = 1'b1;
                drp.addr  = `PA_ADDR_RXCDR_CFG1;
                drp.wdata = drp_data_t'(cdr_pi_q) << `PA_CDR_PI_SHIFT;
            end
            default: begin
                drp.req = 1'b0;
            end
        endcase
    end

endmodule

// ==== rxrecclk_bitslip_top.sv ====
// --------------------------------------
// Top level of the recovered-clock
// bitslip logic. Sequencer and DRP port
// joined by one drp_req_if, no registers.
// --------------------------------------
`timescale 1ns/1ps

module rxrecclk_bitslip_top (
    // Clock and reset
    input  logic                         clk_freerun,
    input  logic                         rst_clk_freerun,
    // User bitslip
    input  logic                         i_bitslip,
    output logic                         o_bitslip_rdy,
    // MGT DRP
    output logic                         o_mgt_drpen,
    output logic                         o_mgt_drpwe,
    output phase_aligner_pkg::drp_addr_t o_mgt_drpaddr,
    output phase_aligner_pkg::drp_data_t o_mgt_drpdi,
    input  logic                         i_mgt_drprdy,
    input  phase_aligner_pkg::drp_data_t i_mgt_drpdo,
    // MGT DMONITOR
    input  phase_aligner_pkg::drp_data_t i_dmonitorout,
    // MGT CDR override
    output logic                         o_rxcdrovrden
);

    // --------------------------------------
    // Internal DRP request channel
    // --------------------------------------
    drp_req_if drp_req_if_inst ();

    // Configuration and PI walk FSM
    bitslip_sequencer bitslip_sequencer_inst (
        .i_clk_freerun     (clk_freerun),
        .i_rst_clk_freerun (rst_clk_freerun),
        .i_bitslip         (i_bitslip),
        .i_dmonitorout     (i_dmonitorout),
        .drp               (drp_req_if_inst.requester),
        .o_bitslip_rdy     (o_bitslip_rdy),
        .o_rxcdrovrden     (o_rxcdrovrden)
    );

    // Enable/ready cycle on the MGT pins
    mgt_drp_port mgt_drp_port_inst (
        .i_clk_freerun     (clk_freerun),
        .i_rst_clk_freerun (rst_clk_freerun),
        .drp               (drp_req_if_inst.port),
        .o_mgt_drpen       (o_mgt_drpen),
        .o_mgt_drpwe       (o_mgt_drpwe),
        .o_mgt_drpaddr     (o_mgt_drpaddr),
        .o_mgt_drpdi       (o_mgt_drpdi),
        .i_mgt_drprdy      (i_mgt_drprdy),
        .i_mgt_drpdo       (i_mgt_drpdo)
    );

endmodule

// ==== tb_drp_model.sv ====
// --------------------------------------
// Behavioral MGT DRP slave for the
// testbench. Random ready latency per
// access, logs each access on a strobe.
// --------------------------------------
`timescale 1ns/1ps

module tb_drp_model #(
    parameter phase_aligner_pkg::drp_data_t READ_VALUE = 16'h0000
) (
    input  logic                         i_clk_freerun,
    input  logic                         i_rst_clk_freerun,
    // DRP pins from the DUT
    input  logic                         i_drpen,
    input  logic                         i_drpwe,
    input  phase_aligner_pkg::drp_addr_t i_drpaddr,
    input  phase_aligner_pkg::drp_data_t i_drpdi,
    output logic                         o_drprdy,
    output phase_aligner_pkg::drp_data_t o_drpdo,
    // One strobe per accepted access
    output logic                         o_acc_strobe,
    output logic                         o_acc_we,
    output phase_aligner_pkg::drp_addr_t o_acc_addr,
    output phase_aligner_pkg::drp_data_t o_acc_data,
    output int                           o_proto_errs
);
    import phase_aligner_pkg::*;

    logic        rdy_q     = 1'b0;
    drp_data_t   do_q      = '0;
    logic        strobe_q  = 1'b0;
    logic        busy      = 1'b0;
    logic        after_rdy = 1'b0;
    int unsigned wait_cnt  = 0;
    int          errs      = 0;
    logic        we_q      = 1'b0;
    drp_addr_t   addr_q    = '0;
    drp_data_t   di_q      = '0;

    always @(posedge i_clk_freerun) begin
        if (i_rst_clk_freerun) begin
            rdy_q     <= 1'b0;
            strobe_q  <= 1'b0;
            busy      <= 1'b0;
            after_rdy <= 1'b0;
        end else begin
            rdy_q     <= 1'b0;
            strobe_q  <= 1'b0;
            after_rdy <= 1'b0;
            if (rdy_q) begin
                // Ready cycle, enable must still be up
                after_rdy <= 1'b1;
                if (!i_drpen) begin
                    errs <= errs + 1;
                    $display("DRP enable was low in the ready cycle at %0t", $time);
                end
            end else if (busy) begin
                if (!i_drpen) begin
                    errs <= errs + 1;
                    $display("DRP enable dropped before ready at %0t", $time);
                end else if (i_drpwe !== we_q || i_drpaddr !== addr_q || i_drpdi !== di_q) begin
                    errs <= errs + 1;
                    $display("DRP pins changed while enable was high at %0t", $time);
                end
                if (wait_cnt == 0) begin
                    busy  <= 1'b0;
                    rdy_q <= 1'b1;
                    do_q  <= (!we_q && addr_q == 10'h03A) ? READ_VALUE : 16'h0000;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (i_drpen) begin
                // New access
                if (after_rdy) begin
                    errs <= errs + 1;
                    $display("DRP enable had no idle cycle between accesses at %0t", $time);
                end
                busy     <= 1'b1;
                wait_cnt <= $urandom % 8;
                we_q     <= i_drpwe;
                addr_q   <= i_drpaddr;
                di_q     <= i_drpdi;
                strobe_q <= 1'b1;
            end
        end
    end

    assign o_drprdy     = rdy_q;
    assign o_drpdo      = do_q;
    assign o_acc_strobe = strobe_q;
    assign o_acc_we     = we_q;
    assign o_acc_addr   = addr_q;
    assign o_acc_data   = di_q;
    assign o_proto_errs = errs;

endmodule

// ==== tb_rxrecclk_bitslip.sv ====
// --------------------------------------
// Testbench for rxrecclk_bitslip_top.
// Checks the DMONITOR startup, then runs
// a table of bitslips and their writes.
// --------------------------------------
`timescale 1ns/1ps

module tb_rxrecclk_bitslip;
    import phase_aligner_pkg::*;

    localparam int        NUM_ENTRIES    = 6;
    localparam int        CYCLE_LIMIT    = NUM_ENTRIES * 4 * 12 + 200;
    localparam drp_data_t DMON_CFG_VALUE = 16'hA5C3;

    logic      clk_freerun = 1'b0;
    logic      rst_clk_freerun;
    logic      i_bitslip;
    logic      o_bitslip_rdy;
    logic      o_mgt_drpen;
    logic      o_mgt_drpwe;
    drp_addr_t o_mgt_drpaddr;
    drp_data_t o_mgt_drpdi;
    logic      i_mgt_drprdy;
    drp_data_t i_mgt_drpdo;
    drp_data_t i_dmonitorout;
    logic      o_rxcdrovrden;

    // Access log from the DRP model
    logic      acc_strobe;
    logic      acc_we;
    drp_addr_t acc_addr;
    drp_data_t acc_data;
    int        proto_errs;
    logic      acc_we_q[$];
    drp_addr_t acc_addr_q[$];
    drp_data_t acc_data_q[$];

    int err_cnt   = 0;
    int ovrd_cnt  = 0;
    int cycle_cnt = 0;

    // ---------------------------------------
    // Stimulus table with the PI in dmon[6:0]
    // ---------------------------------------
    drp_data_t tbl_dmon [0:NUM_ENTRIES-1] = '{
        16'h0005, 16'hFF7F, 16'h0060, 16'h1270, 16'h0000, 16'h007E
    };
    logic tbl_double [0:NUM_ENTRIES-1] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    drp_data_t tbl_exp [0:NUM_ENTRIES-1][0:3] = '{
        '{16'h4A00, 16'h8A00, 16'hCA00, 16'h0A00},
        '{16'h3E00, 16'h7E00, 16'hBE00, 16'hFE00},
        '{16'h0000, 16'h4000, 16'h8000, 16'hC000},
        '{16'h2000, 16'h6000, 16'hA000, 16'hE000},
        '{16'h4000, 16'h8000, 16'hC000, 16'h0000},
        '{16'h3C00, 16'h7C00, 16'hBC00, 16'hFC00}
    };

    always #2 clk_freerun = ~clk_freerun;

    rxrecclk_bitslip_top rxrecclk_bitslip_top_inst (
        .clk_freerun     (clk_freerun),
        .rst_clk_freerun (rst_clk_freerun),
        .i_bitslip       (i_bitslip),
        .o_bitslip_rdy   (o_bitslip_rdy),
        .o_mgt_drpen     (o_mgt_drpen),
        .o_mgt_drpwe     (o_mgt_drpwe),
        .o_mgt_drpaddr   (o_mgt_drpaddr),
        .o_mgt_drpdi     (o_mgt_drpdi),
        .i_mgt_drprdy    (i_mgt_drprdy),
        .i_mgt_drpdo     (i_mgt_drpdo),
        .i_dmonitorout   (i_dmonitorout),
        .o_rxcdrovrden   (o_rxcdrovrden)
    );

    tb_drp_model #(.READ_VALUE(DMON_CFG_VALUE)) drp_model_inst (
        .i_clk_freerun     (clk_freerun),
        .i_rst_clk_freerun (rst_clk_freerun),
        .i_drpen           (o_mgt_drpen),
        .i_drpwe           (o_mgt_drpwe),
        .i_drpaddr         (o_mgt_drpaddr),
        .i_drpdi           (o_mgt_drpdi),
        .o_drprdy          (i_mgt_drprdy),
        .o_drpdo           (i_mgt_drpdo),
        .o_acc_strobe      (acc_strobe),
        .o_acc_we          (acc_we),
        .o_acc_addr        (acc_addr),
        .o_acc_data        (acc_data),
        .o_proto_errs      (proto_errs)
    );

    // Monitors for DRP accesses and override pulses
    always @(posedge clk_freerun) begin
        if (acc_strobe) begin
            acc_we_q.push_back(acc_we);
            acc_addr_q.push_back(acc_addr);
            acc_data_q.push_back(acc_data);
        end
        if (o_rxcdrovrden) begin
            ovrd_cnt <= ovrd_cnt + 1;
        end
    end

    // Run limit
    always @(posedge clk_freerun) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    // ---------------------------------------
    // Compare tasks
    // ---------------------------------------
    task automatic check_addr(input string name, input drp_addr_t got, input drp_addr_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input drp_data_t got, input drp_data_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            err_cnt++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // Oldest logged access or zeros when none is left
    task automatic pop_access(output logic we, output drp_addr_t addr, output drp_data_t data);
        we   = 1'b0;
        addr = '0;
        data = '0;
        if (acc_addr_q.size() == 0) begin
            err_cnt++;
            $display("Expected a DRP access but none was logged");
        end else begin
            we   = acc_we_q.pop_front();
            addr = acc_addr_q.pop_front();
            data = acc_data_q.pop_front();
        end
    endtask

    task automatic wait_ready();
        while (!o_bitslip_rdy) begin
            @(posedge clk_freerun);
        end
    endtask

    // DMONITOR read, then write-back with CDR select in the upper byte
    task automatic check_startup();
        logic      we;
        drp_addr_t addr;
        drp_data_t data;
        @(posedge clk_freerun);
        if (o_bitslip_rdy !== 1'b0) begin
            err_cnt++;
            $display("Bitslip ready was not low after reset");
        end
        wait_ready();
        check_count("startup DRP accesses", acc_addr_q.size(), 2);
        pop_access(we, addr, data);
        check_count("o_mgt_drpwe", int'(we), 0);
        check_addr("o_mgt_drpaddr", addr, 10'h03A);
        pop_access(we, addr, data);
        check_count("o_mgt_drpwe", int'(we), 1);
        check_addr("o_mgt_drpaddr", addr, 10'h03A);
        check_data("o_mgt_drpdi", data, {8'h01, DMON_CFG_VALUE[7:0]});
        check_count("o_rxcdrovrden pulses at startup", ovrd_cnt, 0);
    endtask

    // One bitslip with its four RXCDR_CFG1 writes
    task automatic run_entry(input int idx);
        int        ovrd_start;
        int        wait_cycles;
        logic      we;
        drp_addr_t addr;
        drp_data_t data;
        wait_ready();
        check_count("DRP accesses before the slip", acc_addr_q.size(), 0);
        acc_we_q.delete();
        acc_addr_q.delete();
        acc_data_q.delete();
        i_dmonitorout <= tbl_dmon[idx];
        @(posedge clk_freerun);
        i_bitslip <= 1'b1;
        @(posedge clk_freerun);
        i_bitslip <= 1'b0;
        ovrd_start = ovrd_cnt;
        @(posedge clk_freerun);
        if (o_bitslip_rdy) begin
            err_cnt++;
            $display("Bitslip ready stayed high after the edge in entry %0d", idx);
        end
        wait_cycles = 0;
        while (!o_bitslip_rdy) begin
            // Extra pulse while the walk is running
            if (tbl_double[idx] && wait_cycles == 3) begin
                i_bitslip <= 1'b1;
            end
            if (tbl_double[idx] && wait_cycles == 5) begin
                i_bitslip <= 1'b0;
            end
            wait_cycles++;
            @(posedge clk_freerun);
        end
        check_count("o_rxcdrovrden pulses", ovrd_cnt - ovrd_start, 4);
        check_count("RXCDR_CFG1 writes", acc_addr_q.size(), 4);
        for (int k = 0; k < 4; k++) begin
            pop_access(we, addr, data);
            check_count("o_mgt_drpwe", int'(we), 1);
            check_addr("o_mgt_drpaddr", addr, 10'h00F);
            check_data("o_mgt_drpdi", data, tbl_exp[idx][k]);
        end
    endtask

    // ---------------------------------------
    // Main sequence
    // ---------------------------------------
    initial begin
        int total;
        void'($urandom(12148));
        rst_clk_freerun = 1'b1;
        i_bitslip       = 1'b0;
        i_dmonitorout   = '0;
        repeat (10) @(posedge clk_freerun);
        rst_clk_freerun <= 1'b0;
        check_startup();
        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            run_entry(idx);
        end
        // A late slip would show up here
        repeat (20) @(posedge clk_freerun);
        check_count("DRP writes after the last slip", acc_addr_q.size(), 0);
        total = err_cnt + proto_errs;
        $display("Errors: %0d value, %0d DRP protocol, %0d total", err_cnt, proto_errs, total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
phase_aligner_pkg.sv
drp_req_if.sv
mgt_drp_port.sv
bitslip_sequencer.sv
rxrecclk_bitslip_top.sv
tb_drp_model.sv
tb_rxrecclk_bitslip.sv

// ==== Makefile ====
# Verilator build and run for the recovered-clock bitslip testbench

TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_rxrecclk_bitslip
RTL_TOP  := rxrecclk_bitslip_top
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

lint:
	$(TOOL) --lint-only -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
